/* build.f */
hdl/eth_frame_pkg.sv
hdl/video_pkg.sv
hdl/crc_if.sv
hdl/crc32_gmii.sv
hdl/frame_hdr_regs.sv
hdl/pixel_serializer.sv
hdl/frame_sequencer.sv
hdl/gmii_video_tx.sv
test/tb_gmii_video_tx.sv

/* Bender.yml */
package:
  name: gmii_video_tx

sources:
  - hdl/eth_frame_pkg.sv
  - hdl/video_pkg.sv
  - hdl/crc_if.sv
  - hdl/crc32_gmii.sv
  - hdl/frame_hdr_regs.sv
  - hdl/pixel_serializer.sv
  - hdl/frame_sequencer.sv
  - hdl/gmii_video_tx.sv
  - target: test
    files:
      - test/tb_gmii_video_tx.sv

/* test/tb_gmii_video_tx.sv */
`default_nettype none

module tb_gmii_video_tx;

	localparam int PAYLOAD        = 16;
	localparam int LINE_WORDS     = 1 + PAYLOAD / 2;
	localparam int FRAME_LEN      = 8 + 42 + 1 + 2 + PAYLOAD + 4;
	localparam int IP_OFS         = 8 + 14;
	localparam int MIN_GAP        = 12;
	localparam int TIMEOUT_CYCLES = 6 * (FRAME_LEN + 16 + MIN_GAP) + 200;

	logic                   fifo_clk;
	logic                   sys_rst;
	logic                   id;
	logic                   sw;
	logic                   empty = 1'b1;
	logic                   wr_en;
	logic                   rd_en;
	logic                   tx_en;
	logic                   push_en;
	video_pkg::pixel_word_t dout = '0;
	video_pkg::pixel_word_t push_data;
	eth_frame_pkg::byte_t   txd;

	video_pkg::pixel_word_t fifo_q [$];
	video_pkg::pixel_word_t lines [2][LINE_WORDS];
	eth_frame_pkg::byte_t   exp_frame [2][FRAME_LEN];
	eth_frame_pkg::byte_t   got_frame [2][FRAME_LEN];

	int          exp_len;
	int          got_len [2];
	int          pop_count;
	int          mismatch_errs;
	int          other_errs;
	int          cycle_count;

	gmii_video_tx #(
		.payload_bytes (PAYLOAD)
	) dut0 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.id       (id),
		.sw       (sw),
		.dout     (dout),
		.empty    (empty),
		.wr_en    (wr_en),
		.rd_en    (rd_en),
		.tx_en    (tx_en),
		.txd      (txd)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #4 fifo_clk = ~fifo_clk;
	end

	// Show-ahead FIFO with the head word visible whenever not empty
	always @(posedge fifo_clk) begin
		if (rd_en === 1'b1) begin
			if (fifo_q.size() == 0) begin
				other_errs++;
				$display("DUT popped the FIFO while it was empty");
			end else begin
				fifo_q.delete(0);
			end
			pop_count++;
		end
		if (push_en === 1'b1)
			fifo_q.push_back(push_data);
		empty <= (fifo_q.size() == 0);
		dout  <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge fifo_clk);
			cycle_count++;
		end
		$display("Timeout: run went past %0d cycles waiting for the DUT", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	// ------------------------------------------------------------
	// Compare helpers
	// ------------------------------------------------------------
	task automatic compare_byte(input string name, input eth_frame_pkg::byte_t got,
		input eth_frame_pkg::byte_t exp);
		if (got !== exp) begin
			mismatch_errs++;
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_errs++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			mismatch_errs++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// Reference frame builder
	// ------------------------------------------------------------
	function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] b);
		logic fb;
		for (int k = 0; k < 8; k++) begin
			fb = c[0] ^ b[k];
			c  = (c >> 1) ^ (32'hedb8_8320 & {32{fb}});
		end
		return c;
	endfunction

	// End-around carry add
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	task automatic put_byte(input int sel, input eth_frame_pkg::byte_t b);
		if (exp_len < FRAME_LEN)
			exp_frame[sel][exp_len] = b;
		exp_len++;
	endtask

	task automatic put_word(input int sel, input logic [15:0] w);
		put_byte(sel, w[15:8]);
		put_byte(sel, w[7:0]);
	endtask

	task automatic build_expected(input int sel, input logic id_v, input logic sw_v);
		logic [15:0] sum;
		logic [31:0] crc;
		logic [47:0] wb;
		exp_len = 0;
		for (int i = 0; i < 7; i++)
			put_byte(sel, 8'h55);
		put_byte(sel, 8'hd5);
		// MAC header
		put_word(sel, 16'h0023);
		put_word(sel, 16'h4567);
		put_word(sel, {8'h89, 8'h02 - 8'(id_v)});
		put_word(sel, 16'h0023);
		put_word(sel, 16'h4567);
		put_word(sel, {8'h89, 8'h01 + 8'(id_v)});
		put_word(sel, 16'h0800);
		// IPv4 header with the checksum filled in below
		put_word(sel, 16'h4500);
		put_word(sel, 16'(PAYLOAD + 31));
		put_word(sel, 16'h0000);
		put_word(sel, 16'h4000);
		put_word(sel, 16'h4011);
		put_word(sel, 16'h0000);
		put_word(sel, 16'hc0a8);
		put_word(sel, {8'h00, 8'h01 + 8'(id_v)});
		put_word(sel, 16'hc0a8);
		put_word(sel, {8'h00, 8'h02 - 8'(id_v)});
		// UDP
		put_word(sel, 16'd12344);
		put_word(sel, 16'd12345);
		put_word(sel, 16'(PAYLOAD + 11));
		put_word(sel, 16'h0000);
		put_byte(sel, 8'h00);
		wb = lines[sel][0];
		put_byte(sel, wb[43:36]);
		put_byte(sel, {wb[27:24], wb[47:44]});
		for (int k = 1; k < LINE_WORDS; k++) begin
			wb = lines[sel][k];
			put_byte(sel, sw_v ? wb[15:8] : wb[45:38]);
			put_byte(sel, wb[23:16]);
		end
		sum = 16'h0000;
		for (int i = 0; i < 10; i++)
			sum = ones_add(sum, {exp_frame[sel][IP_OFS + 2 * i], exp_frame[sel][IP_OFS + 2 * i + 1]});
		sum = ~sum;
		exp_frame[sel][IP_OFS + 10] = sum[15:8];
		exp_frame[sel][IP_OFS + 11] = sum[7:0];
		crc = 32'hffff_ffff;
		for (int i = 8; i < exp_len; i++)
			crc = crc32_byte(crc, exp_frame[sel][i]);
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			put_byte(sel, crc[8 * i +: 8]);
	endtask

	// ------------------------------------------------------------
	// Stimulus and capture
	// ------------------------------------------------------------
	task automatic fill_line(input int sel, input bit rand_words, input int base);
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		for (int k = 0; k < LINE_WORDS; k++) begin
			if (rand_words) begin
				r_hi = $urandom;
				r_lo = $urandom;
				lines[sel][k] = {r_hi[15:0], r_lo};
			end else begin
				lines[sel][k] = 48'h1357_9bdf_2468 + 48'(k + base) * 48'h0111_2233_4455;
			end
		end
	endtask

	task automatic set_mode(input logic id_v, input logic sw_v);
		@(posedge fifo_clk);
		id <= id_v;
		sw <= sw_v;
	endtask

	task automatic write_line(input int sel);
		for (int k = 0; k < LINE_WORDS; k++) begin
			@(posedge fifo_clk);
			push_en   <= 1'b1;
			push_data <= lines[sel][k];
		end
		@(posedge fifo_clk);
		push_en <= 1'b0;
	endtask

	// Falling edge of wr_en marks the line as complete
	task automatic pulse_line_done();
		@(posedge fifo_clk);
		wr_en <= 1'b1;
		@(posedge fifo_clk);
		wr_en <= 1'b0;
	endtask

	// Called at a falling clock edge
	task automatic capture_frame(input int sel, output int idle_cycles);
		idle_cycles = 0;
		while (tx_en !== 1'b1) begin
			idle_cycles++;
			@(negedge fifo_clk);
		end
		got_len[sel] = 0;
		while (tx_en === 1'b1) begin
			if (got_len[sel] < FRAME_LEN)
				got_frame[sel][got_len[sel]] = txd;
			got_len[sel]++;
			@(negedge fifo_clk);
		end
	endtask

	task automatic compare_frame(input int sel, input string tag);
		int n;
		compare_count({tag, " tx_en cycles"}, got_len[sel], FRAME_LEN);
		n = (got_len[sel] < FRAME_LEN) ? got_len[sel] : FRAME_LEN;
		for (int i = 0; i < n; i++)
			compare_byte($sformatf("%s txd[%0d]", tag, i), got_frame[sel][i], exp_frame[sel][i]);
	endtask

	task automatic run_line(input int sel, input string tag);
		int idle;
		write_line(sel);
		pulse_line_done();
		@(negedge fifo_clk);
		capture_frame(sel, idle);
		compare_frame(sel, tag);
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic no_frame_without_line();
		int busy;
		busy = 0;
		@(negedge fifo_clk);
		compare_bit("tx_en after reset", tx_en, 1'b0);
		compare_bit("rd_en after reset", rd_en, 1'b0);
		compare_byte("txd after reset", txd, 8'h00);
		fill_line(0, 1'b0, 0);
		set_mode(1'b0, 1'b0);
		write_line(0);
		repeat (24) begin
			@(negedge fifo_clk);
			if (tx_en !== 1'b0 || rd_en !== 1'b0)
				busy++;
		end
		compare_count("active cycles without line", busy, 0);
	endtask

	// Line is already queued by the previous test
	task automatic default_yuv_frame();
		int idle;
		build_expected(0, 1'b0, 1'b0);
		pulse_line_done();
		@(negedge fifo_clk);
		capture_frame(0, idle);
		compare_frame(0, "default frame");
	endtask

	task automatic id_offset_frame();
		fill_line(0, 1'b0, 5);
		set_mode(1'b1, 1'b0);
		build_expected(0, 1'b1, 1'b0);
		run_line(0, "id offset frame");
	endtask

	task automatic rgb_random_frame();
		fill_line(0, 1'b1, 0);
		set_mode(1'b0, 1'b1);
		build_expected(0, 1'b0, 1'b1);
		run_line(0, "rgb frame");
	endtask

	task automatic fifo_read_count();
		int pops_before;
		fill_line(0, 1'b1, 0);
		set_mode(1'b1, 1'b0);
		build_expected(0, 1'b1, 1'b0);
		pops_before = pop_count;
		run_line(0, "read count frame");
		compare_count("rd_en pulses", pop_count - pops_before, LINE_WORDS);
		compare_count("FIFO words left", fifo_q.size(), 0);
	endtask

	task automatic back_to_back_lines();
		int idle;
		int gap;
		fill_line(0, 1'b0, 9);
		fill_line(1, 1'b1, 0);
		set_mode(1'b0, 1'b0);
		build_expected(0, 1'b0, 1'b0);
		build_expected(1, 1'b0, 1'b0);
		write_line(0);
		pulse_line_done();
		fork
			begin
				@(negedge fifo_clk);
				capture_frame(0, idle);
				capture_frame(1, gap);
			end
			begin
				// Second line lands while the first frame is on the wire
				while (tx_en !== 1'b1)
					@(negedge fifo_clk);
				write_line(1);
				pulse_line_done();
			end
		join
		if (gap < MIN_GAP) begin
			other_errs++;
			$display("Frames too close together: only %0d idle cycles between them", gap);
		end
		compare_frame(0, "first b2b frame");
		compare_frame(1, "second b2b frame");
	endtask

	initial begin
		void'($urandom(32'h61ee_0114));
		sys_rst       = 1'b1;
		id            = 1'b0;
		sw            = 1'b0;
		wr_en         = 1'b0;
		push_en       = 1'b0;
		push_data     = '0;
		mismatch_errs = 0;
		other_errs    = 0;
		pop_count     = 0;
		repeat (2) @(posedge fifo_clk);
		sys_rst <= 1'b0;

		no_frame_without_line();
		default_yuv_frame();
		id_offset_frame();
		rgb_random_frame();
		fifo_read_count();
		back_to_back_lines();

		$display("Errors: %0d value mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/gmii_video_tx.sv */
`default_nettype none

module gmii_video_tx #(
	parameter int                       payload_bytes = video_pkg::DEF_PAYLOAD_BYTES,
	parameter eth_frame_pkg::mac_addr_t src_mac       = eth_frame_pkg::DEF_SRC_MAC,
	parameter eth_frame_pkg::mac_addr_t dst_mac       = eth_frame_pkg::DEF_DST_MAC,
	parameter eth_frame_pkg::ip_addr_t  src_ip        = eth_frame_pkg::DEF_SRC_IP,
	parameter eth_frame_pkg::ip_addr_t  dst_ip        = eth_frame_pkg::DEF_DST_IP
) (
	input  wire logic            fifo_clk,
	input  wire logic            sys_rst,
	input  wire logic            id,
	input  wire logic            sw,
	// Show-ahead line FIFO
	input  wire logic [47:0]     dout,
	input  wire logic            empty,
	input  wire logic            wr_en,
	output logic                 rd_en,
	// GMII transmit
	output logic                 tx_en,
	output eth_frame_pkg::byte_t txd
);

	logic [5:0]           hdr_index;
	eth_frame_pkg::byte_t hdr_byte;
	logic                 resol_step;
	logic                 pay_step;
	eth_frame_pkg::byte_t pix_byte;

	crc_if crc_bus ();

	frame_sequencer #(
		.payload_bytes (payload_bytes)
	) u_seq (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.empty      (empty),
		.wr_en      (wr_en),
		.hdr_index  (hdr_index),
		.hdr_byte   (hdr_byte),
		.resol_step (resol_step),
		.pay_step   (pay_step),
		.pix_byte   (pix_byte),
		.crc        (crc_bus.sequencer),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	frame_hdr_regs #(
		.payload_bytes (payload_bytes),
		.src_mac       (src_mac),
		.dst_mac       (dst_mac),
		.src_ip        (src_ip),
		.dst_ip        (dst_ip)
	) u_hdr (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.id        (id),
		.hdr_index (hdr_index),
		.hdr_byte  (hdr_byte)
	);

	pixel_serializer u_pix (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.sw         (sw),
		.dout       (dout),
		.resol_step (resol_step),
		.pay_step   (pay_step),
		.pix_byte   (pix_byte),
		.rd_en      (rd_en)
	);

	crc32_gmii u_crc (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.crc      (crc_bus.engine)
	);

endmodule

`default_nettype wire

/* hdl/frame_sequencer.sv */
`default_nettype none

module frame_sequencer #(
	parameter int payload_bytes = 1200
) (
	input  wire logic                  fifo_clk,
	input  wire logic                  sys_rst,
	input  wire logic                  empty,
	input  wire logic                  wr_en,
	output logic [5:0]                 hdr_index,
	input  wire eth_frame_pkg::byte_t  hdr_byte,
	output logic                       resol_step,
	output logic                       pay_step,
	input  wire eth_frame_pkg::byte_t  pix_byte,
	crc_if.sequencer                   crc,
	output logic                       tx_en,
	output eth_frame_pkg::byte_t       txd
);

	localparam int cnt_w = ($clog2(payload_bytes) < 6) ? 6 : $clog2(payload_bytes);
	localparam int gap_w = $clog2(eth_frame_pkg::IFG_LEN);

	eth_frame_pkg::frame_state_t state;
	eth_frame_pkg::frame_state_t next_seg;

	logic [cnt_w-1:0]     byte_cnt;
	logic [gap_w-1:0]     gap_cnt;
	logic                 wr_en_q;
	logic                 line_armed;
	logic                 start;
	logic                 seg_last;
	logic                 tx_on;
	eth_frame_pkg::byte_t tx_byte;

	assign start = (state == eth_frame_pkg::IDLE) && line_armed && !empty;

	// ------------------------------------------------------------
	// Byte source and segment end per state
	// ------------------------------------------------------------
	always_comb begin
		tx_byte  = '0;
		tx_on    = 1'b1;
		seg_last = 1'b0;
		next_seg = state;
		case (state)
			eth_frame_pkg::PREAMBLE: begin
				tx_byte  = eth_frame_pkg::PREAMBLE_BYTE;
				seg_last = (byte_cnt == cnt_w'(eth_frame_pkg::PREAMBLE_LEN - 1));
				next_seg = eth_frame_pkg::SFD;
			end
			eth_frame_pkg::SFD: begin
				tx_byte  = eth_frame_pkg::SFD_BYTE;
				seg_last = 1'b1;
				next_seg = eth_frame_pkg::HEADER;
			end
			eth_frame_pkg::HEADER: begin
				tx_byte  = hdr_byte;
				seg_last = (byte_cnt == cnt_w'(eth_frame_pkg::HDR_LEN - 1));
				next_seg = eth_frame_pkg::PKT_ID;
			end
			eth_frame_pkg::PKT_ID: begin
				tx_byte  = eth_frame_pkg::PKT_ID_VIDEO;
				seg_last = 1'b1;
				next_seg = eth_frame_pkg::RESOL;
			end
			eth_frame_pkg::RESOL: begin
				tx_byte  = pix_byte;
				seg_last = (byte_cnt == cnt_w'(1));
				next_seg = eth_frame_pkg::PAYLOAD;
			end
			eth_frame_pkg::PAYLOAD: begin
				tx_byte  = pix_byte;
				seg_last = (byte_cnt == cnt_w'(payload_bytes - 1));
				next_seg = eth_frame_pkg::FCS;
			end
			eth_frame_pkg::FCS: begin
				// Least significant byte first
				tx_byte  = crc.fcs[8 * byte_cnt[1:0] +: 8];
				seg_last = (byte_cnt == cnt_w'(3));
				next_seg = eth_frame_pkg::GAP;
			end
			default: tx_on = 1'b0;
		endcase
	end

	assign hdr_index  = (state == eth_frame_pkg::HEADER) ? byte_cnt[5:0] : 6'd0;
	assign resol_step = (state == eth_frame_pkg::RESOL);
	assign pay_step   = (state == eth_frame_pkg::PAYLOAD);

	// CRC sees exactly the bytes from dst MAC through payload
	assign crc.init    = (state == eth_frame_pkg::SFD);
	assign crc.data_en = (state == eth_frame_pkg::HEADER) || (state == eth_frame_pkg::PKT_ID)
		|| (state == eth_frame_pkg::RESOL) || (state == eth_frame_pkg::PAYLOAD);
	assign crc.data    = tx_byte;

	// ------------------------------------------------------------
	// State, counters, arming and GMII registers
	// ------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state      <= eth_frame_pkg::IDLE;
			byte_cnt   <= '0;
			gap_cnt    <= '0;
			wr_en_q    <= 1'b0;
			line_armed <= 1'b0;
			tx_en      <= 1'b0;
			txd        <= '0;
		end else begin
			wr_en_q <= wr_en;
			tx_en   <= tx_on;
			txd     <= tx_byte;

			// A newly finished line wins over the clear at frame start
			if (wr_en_q && !wr_en)
				line_armed <= 1'b1;
			else if (start)
				line_armed <= 1'b0;

			case (state)
				eth_frame_pkg::IDLE: begin
					byte_cnt <= '0;
					if (start)
						state <= eth_frame_pkg::PREAMBLE;
				end
				eth_frame_pkg::GAP: begin
					if (gap_cnt == '0)
						state <= eth_frame_pkg::IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default: begin
					if (seg_last) begin
						byte_cnt <= '0;
						state    <= next_seg;
						if (next_seg == eth_frame_pkg::GAP)
							gap_cnt <= gap_w'(eth_frame_pkg::IFG_LEN - 1);
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/pixel_serializer.sv */
`default_nettype none

module pixel_serializer (
	input  wire logic                  fifo_clk,
	input  wire logic                  sys_rst,
	input  wire logic                  sw,
	input  wire video_pkg::pixel_word_t dout,
	input  wire logic                  resol_step,
	input  wire logic                  pay_step,
	output eth_frame_pkg::byte_t       pix_byte,
	output logic                       rd_en
);

	video_pkg::byte_mode_t mode;

	logic                 step;
	logic                 phase;
	eth_frame_pkg::byte_t first_byte;
	eth_frame_pkg::byte_t second_byte;
	eth_frame_pkg::byte_t hold_byte;

	assign mode = video_pkg::byte_mode_t'(sw);
	assign step = resol_step | pay_step;

	// Both bytes of the current word
	always_comb begin
		if (resol_step) begin
			first_byte  = dout.resol.res_hi;
			second_byte = {dout.resol.res_lo_h, dout.resol.res_lo_l};
		end else begin
			first_byte  = (mode == video_pkg::MODE_RGB) ? dout.rgb.g_byte : dout.yuv.y_byte;
			// Chroma and red sit in the same bits
			second_byte = dout.yuv.c_byte;
		end
	end

	// Second byte comes from the hold register, so the pop can overlap it
	assign pix_byte = phase ? hold_byte : first_byte;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			phase <= 1'b0;
			rd_en <= 1'b0;
		end else begin
			rd_en <= step & ~phase;
			if (step)
				phase <= ~phase;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (step && !phase)
			hold_byte <= second_byte;
	end

endmodule

`default_nettype wire

/* hdl/frame_hdr_regs.sv */
`default_nettype none

module frame_hdr_regs #(
	parameter int                       payload_bytes = 1200,
	parameter eth_frame_pkg::mac_addr_t src_mac       = eth_frame_pkg::DEF_SRC_MAC,
	parameter eth_frame_pkg::mac_addr_t dst_mac       = eth_frame_pkg::DEF_DST_MAC,
	parameter eth_frame_pkg::ip_addr_t  src_ip        = eth_frame_pkg::DEF_SRC_IP,
	parameter eth_frame_pkg::ip_addr_t  dst_ip        = eth_frame_pkg::DEF_DST_IP
) (
	input  wire logic                  fifo_clk,
	input  wire logic                  sys_rst,
	input  wire logic                  id,
	input  wire logic [5:0]            hdr_index,
	output eth_frame_pkg::byte_t       hdr_byte
);

	// IP: 20 hdr + 8 UDP + id + 2 resolution; UDP: 8 + id + 2
	localparam logic [15:0] ip_total_len = 16'(payload_bytes + 31);
	localparam logic [15:0] udp_len      = 16'(payload_bytes + 11);

	eth_frame_pkg::mac_addr_t src_mac_adj;
	eth_frame_pkg::mac_addr_t dst_mac_adj;
	eth_frame_pkg::ip_addr_t  src_ip_adj;
	eth_frame_pkg::ip_addr_t  dst_ip_adj;

	logic [19:0] csum_sum;
	logic [16:0] csum_fold1;
	logic [15:0] csum_fold2;
	logic [15:0] ip_csum;

	logic [eth_frame_pkg::HDR_LEN*8-1:0] hdr_vec;

	assign src_mac_adj = {src_mac[47:8], src_mac[7:0] + 8'(id)};
	assign dst_mac_adj = {dst_mac[47:8], dst_mac[7:0] - 8'(id)};
	assign src_ip_adj  = {src_ip[31:8], src_ip[7:0] + 8'(id)};
	assign dst_ip_adj  = {dst_ip[31:8], dst_ip[7:0] - 8'(id)};

	// ------------------------------------------------------------
	// IPv4 header checksum
	// ------------------------------------------------------------
	assign csum_sum = eth_frame_pkg::IP_VER_TOS + ip_total_len + eth_frame_pkg::IP_IDENT
		+ eth_frame_pkg::IP_FLAGS + {eth_frame_pkg::IP_TTL, eth_frame_pkg::IP_PROTO_UDP}
		+ src_ip_adj[31:16] + src_ip_adj[15:0] + dst_ip_adj[31:16] + dst_ip_adj[15:0];

	// Two folds absorb every carry of nine words
	assign csum_fold1 = csum_sum[15:0] + csum_sum[19:16];
	assign csum_fold2 = csum_fold1[15:0] + csum_fold1[16];

	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			ip_csum <= '0;
		else
			ip_csum <= ~csum_fold2;
	end

	// ------------------------------------------------------------
	// Header bytes in wire order, index 0 is the first byte
	// ------------------------------------------------------------
	assign hdr_vec = {
		dst_mac_adj, src_mac_adj, eth_frame_pkg::ETHERTYPE_IPV4,
		eth_frame_pkg::IP_VER_TOS, ip_total_len, eth_frame_pkg::IP_IDENT,
		eth_frame_pkg::IP_FLAGS, eth_frame_pkg::IP_TTL, eth_frame_pkg::IP_PROTO_UDP,
		ip_csum, src_ip_adj, dst_ip_adj,
		eth_frame_pkg::UDP_SRC_PORT, eth_frame_pkg::UDP_DST_PORT, udp_len,
		16'h0000 // UDP checksum left out
	};

	always_comb begin
		hdr_byte = '0;
		if (int'(hdr_index) < eth_frame_pkg::HDR_LEN)
			hdr_byte = hdr_vec[8 * (eth_frame_pkg::HDR_LEN - 1 - int'(hdr_index)) +: 8];
	end

endmodule

`default_nettype wire

/* hdl/crc32_gmii.sv */
`default_nettype none

module crc32_gmii (
	input wire logic fifo_clk,
	input wire logic sys_rst,
	crc_if.engine    crc
);

	// Reflected form of 0x04C11DB7
	localparam logic [31:0] crc_poly = 32'hedb8_8320;

	logic [31:0] crc_reg;
	logic [31:0] crc_next;

	// One byte, LSB first as it goes on the wire
	always_comb begin
		crc_next = crc_reg;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0] ^ crc.data[i])
				crc_next = (crc_next >> 1) ^ crc_poly;
			else
				crc_next = crc_next >> 1;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_reg <= eth_frame_pkg::CRC_RESIDUE_INIT;
		end else if (crc.init) begin
			crc_reg <= eth_frame_pkg::CRC_RESIDUE_INIT;
		end else if (crc.data_en) begin
			crc_reg <= crc_next;
		end
	end

	// Byte 0 of the FCS sits in bits 7:0
	assign crc.fcs = ~crc_reg;

endmodule

`default_nettype wire

/* hdl/crc_if.sv */
`default_nettype none

interface crc_if;

	logic                 init;
	logic                 data_en;
	eth_frame_pkg::byte_t data;
	logic [31:0]          fcs;

	// Frame side drives strobes and bytes
	modport sequencer (
		output init, data_en, data,
		input  fcs
	);

	modport engine (
		input  init, data_en, data,
		output fcs
	);

endinterface

`default_nettype wire

/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

	// Three views of the same 48-bit FIFO word
	typedef struct packed {
		logic [1:0]  rsvd_hi;
		logic [7:0]  y_byte;
		logic [13:0] rsvd_mid;
		logic [7:0]  c_byte;
		logic [15:0] rsvd_lo;
	} yuv_view_t;

	typedef struct packed {
		logic [23:0] rsvd_hi;
		logic [7:0]  r_byte;
		logic [7:0]  g_byte;
		logic [7:0]  rsvd_lo;
	} rgb_view_t;

	// Low resolution byte is {res_lo_h, res_lo_l}
	typedef struct packed {
		logic [3:0]  res_lo_l;
		logic [7:0]  res_hi;
		logic [7:0]  rsvd_mid;
		logic [3:0]  res_lo_h;
		logic [23:0] rsvd_lo;
	} resol_view_t;

	typedef union packed {
		yuv_view_t   yuv;
		rgb_view_t   rgb;
		resol_view_t resol;
	} pixel_word_t;

	typedef enum logic {
		MODE_YUV = 1'b0,
		MODE_RGB = 1'b1
	} byte_mode_t;

	localparam int DEF_PAYLOAD_BYTES = 1200;

endpackage

`default_nettype wire

/* hdl/eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	typedef enum logic [3:0] {
		IDLE,
		PREAMBLE,
		SFD,
		HEADER,
		PKT_ID,
		RESOL,
		PAYLOAD,
		FCS,
		GAP
	} frame_state_t;

	// ------------------------------------------------------------
	// Framing and header field values
	// ------------------------------------------------------------
	localparam byte_t       PREAMBLE_BYTE    = 8'h55;
	localparam byte_t       SFD_BYTE         = 8'hd5;
	localparam int          PREAMBLE_LEN     = 7;
	localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
	localparam logic [15:0] IP_VER_TOS       = 16'h4500;
	localparam logic [15:0] IP_IDENT         = 16'h0000;
	localparam logic [15:0] IP_FLAGS         = 16'h4000;
	localparam byte_t       IP_TTL           = 8'h40;
	localparam byte_t       IP_PROTO_UDP     = 8'h11;
	localparam logic [15:0] UDP_SRC_PORT     = 16'd12344;
	localparam logic [15:0] UDP_DST_PORT     = 16'd12345;
	localparam byte_t       PKT_ID_VIDEO     = 8'h00;
	localparam int          HDR_LEN          = 42;
	localparam int          IFG_LEN          = 12;
	localparam logic [31:0] CRC_RESIDUE_INIT = 32'hffff_ffff;

	// Board defaults, id offsets the low bytes
	localparam mac_addr_t   DEF_SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam mac_addr_t   DEF_DST_MAC      = 48'h00_23_45_67_89_02;
	localparam ip_addr_t    DEF_SRC_IP       = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam ip_addr_t    DEF_DST_IP       = {8'd192, 8'd168, 8'd0, 8'd2};

endpackage

`default_nettype wire
